// ==== hw/spmm_dim_pkg.sv ====
`default_nettype none

// matrix geometry and element types shared by the datapath
package spmm_dim_pkg;

    // matrix dimension, also the number of lanes in one beat
    localparam int N = 4;
    localparam int W = 8;
    localparam int LG_N = $clog2(N);
    // flattened position beat*N+lane
    localparam int PTR_W = 2 * LG_N;

    typedef logic [W-1:0] data_t;
    // row, column, lane or beat index
    typedef logic [LG_N-1:0] idx_t;
    typedef logic [PTR_W-1:0] ptr_t;

endpackage

`default_nettype wire

// ==== hw/spmm_ctrl_pkg.sv ====
`default_nettype none

// job sequencing and pipeline timing
package spmm_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_RHS,
        LOAD_LHS,
        DRAIN,
        HOLD_OUT,
        SEND_OUT
    } job_state_t;

    // multiplier register
    localparam int PRODUCT_LATENCY = 1;
    // prefix levels plus the row difference register
    localparam int REDUCE_LATENCY = spmm_dim_pkg::LG_N + 1;
    // left-hand beat to result buffer write
    localparam int PIPE_LATENCY = PRODUCT_LATENCY + REDUCE_LATENCY;

endpackage

`default_nettype wire

// ==== hw/rhs_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rhs_buffer (
    input  wire                      clock,
    input  wire                      rhs_we,
    input  wire spmm_dim_pkg::idx_t  rhs_idx,
    input  wire spmm_dim_pkg::data_t rhs_row [spmm_dim_pkg::N],
    output spmm_dim_pkg::data_t      rhs_mat [spmm_dim_pkg::N][spmm_dim_pkg::N]
);

    // one row per beat, kept until the next load overwrites it
    always_ff @(posedge clock) begin
        if (rhs_we) begin
            for (int c = 0; c < spmm_dim_pkg::N; c++) begin
                rhs_mat[rhs_idx][c] <= rhs_row[c];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/spmm_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_ctrl (
    input  wire                clock,
    input  wire                reset_n,
    input  wire                rhs_start,
    input  wire                lhs_start,
    input  wire                out_start,
    output logic               rhs_ready,
    output logic               lhs_ready,
    output logic               out_ready,
    output logic               out_valid,
    output logic               rhs_we,
    output logic               lhs_accept,
    output logic               lhs_first,
    output logic               out_rd,
    output spmm_dim_pkg::idx_t rhs_idx,
    output spmm_dim_pkg::idx_t lhs_beat,
    output spmm_dim_pkg::idx_t out_idx
);

    localparam int DRAIN_W = $clog2(spmm_ctrl_pkg::PIPE_LATENCY);
    localparam spmm_dim_pkg::idx_t LAST_BEAT = spmm_dim_pkg::idx_t'(spmm_dim_pkg::N - 1);

    spmm_ctrl_pkg::job_state_t state;
    spmm_ctrl_pkg::job_state_t state_next;
    spmm_dim_pkg::idx_t        beat;
    spmm_dim_pkg::idx_t        beat_next;
    logic [DRAIN_W-1:0]        drain_cnt;

    // one beat counter serves all three bursts
    assign rhs_idx   = beat;
    assign lhs_beat  = beat;
    assign out_idx   = beat;
    assign lhs_first = lhs_start && lhs_ready;

    always_comb begin
        state_next = state;
        beat_next  = beat;
        rhs_we     = 1'b0;
        lhs_accept = 1'b0;
        out_rd     = 1'b0;
        case (state)
            spmm_ctrl_pkg::IDLE: begin
                if (rhs_start && rhs_ready) begin
                    rhs_we     = 1'b1;
                    state_next = spmm_ctrl_pkg::LOAD_RHS;
                end
            end
            spmm_ctrl_pkg::LOAD_RHS: begin
                rhs_we = 1'b1;
                if (beat == LAST_BEAT) begin
                    state_next = spmm_ctrl_pkg::LOAD_LHS;
                end
            end
            spmm_ctrl_pkg::LOAD_LHS: begin
                // a nonzero count means the burst is under way
                lhs_accept = lhs_first || (beat != '0);
                if (lhs_accept && beat == LAST_BEAT) begin
                    state_next = spmm_ctrl_pkg::DRAIN;
                end
            end
            spmm_ctrl_pkg::DRAIN: begin
                if (drain_cnt == DRAIN_W'(spmm_ctrl_pkg::PIPE_LATENCY - 1)) begin
                    state_next = spmm_ctrl_pkg::HOLD_OUT;
                end
            end
            spmm_ctrl_pkg::HOLD_OUT: begin
                if (out_start && out_ready) begin
                    out_rd     = 1'b1;
                    state_next = spmm_ctrl_pkg::SEND_OUT;
                end
            end
            spmm_ctrl_pkg::SEND_OUT: begin
                out_rd = 1'b1;
                if (beat == LAST_BEAT) begin
                    state_next = spmm_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = spmm_ctrl_pkg::IDLE;
            end
        endcase
        // wraps back to zero after the last beat of a burst
        if (rhs_we || lhs_accept || out_rd) begin
            beat_next = beat + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= spmm_ctrl_pkg::IDLE;
            beat      <= '0;
            drain_cnt <= '0;
            rhs_ready <= 1'b0;
            lhs_ready <= 1'b0;
            out_ready <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            beat      <= beat_next;
            drain_cnt <= (state == spmm_ctrl_pkg::DRAIN) ? drain_cnt + 1'b1 : '0;
            // readys follow the next state, so they are high exactly in their phase
            // rhs_ready waits until the last output row has left
            rhs_ready <= (state_next == spmm_ctrl_pkg::IDLE) && !out_rd;
            lhs_ready <= (state_next == spmm_ctrl_pkg::LOAD_LHS) && (beat_next == '0);
            out_ready <= (state_next == spmm_ctrl_pkg::HOLD_OUT);
            // out_row is registered on out_rd
            out_valid <= out_rd;
        end
    end

endmodule

`default_nettype wire

// ==== hw/csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire                            lhs_accept,
    input  wire                            lhs_first,
    input  wire spmm_dim_pkg::idx_t        lhs_beat,
    input  wire spmm_dim_pkg::ptr_t        lhs_ptr [spmm_dim_pkg::N],
    output logic [spmm_dim_pkg::N-1:0]     lane_end,
    output spmm_dim_pkg::idx_t             lane_row [spmm_dim_pkg::N]
);

    spmm_dim_pkg::ptr_t            ptr_q [spmm_dim_pkg::N];
    spmm_dim_pkg::ptr_t            ptr_cur [spmm_dim_pkg::N];
    spmm_dim_pkg::ptr_t            pos [spmm_dim_pkg::N];
    logic [spmm_dim_pkg::N-1:0]    end_c;
    spmm_dim_pkg::idx_t            row_c [spmm_dim_pkg::N];

    always_ff @(posedge clock) begin
        if (lhs_first) begin
            ptr_q <= lhs_ptr;
        end
    end

    always_comb begin
        // the first beat uses the pointers straight off the bus
        for (int r = 0; r < spmm_dim_pkg::N; r++) begin
            ptr_cur[r] = lhs_first ? lhs_ptr[r] : ptr_q[r];
        end
        for (int l = 0; l < spmm_dim_pkg::N; l++) begin
            pos[l]   = {lhs_beat, spmm_dim_pkg::idx_t'(l)};
            end_c[l] = 1'b0;
            row_c[l] = '0;
            // row id is the number of row ends strictly before this position
            for (int r = 0; r < spmm_dim_pkg::N; r++) begin
                if (ptr_cur[r] == pos[l]) begin
                    end_c[l] = 1'b1;
                end
                if (ptr_cur[r] < pos[l]) begin
                    row_c[l] = row_c[l] + 1'b1;
                end
            end
        end
    end

    // registered to line up with the product stage
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lane_end <= '0;
        end else begin
            lane_end <= end_c & {spmm_dim_pkg::N{lhs_accept}};
        end
    end

    always_ff @(posedge clock) begin
        lane_row <= row_c;
    end

endmodule

`default_nettype wire

// ==== hw/product_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module product_stage (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      lhs_accept,
    input  wire spmm_dim_pkg::data_t lhs_data [spmm_dim_pkg::N],
    input  wire spmm_dim_pkg::idx_t  lhs_col [spmm_dim_pkg::N],
    input  wire spmm_dim_pkg::data_t rhs_mat [spmm_dim_pkg::N][spmm_dim_pkg::N],
    output spmm_dim_pkg::data_t      prod [spmm_dim_pkg::N][spmm_dim_pkg::N],
    output logic                     prod_valid
);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= lhs_accept;
        end
    end

    // lane i scales the right-hand row picked by its column index
    always_ff @(posedge clock) begin
        if (lhs_accept) begin
            for (int i = 0; i < spmm_dim_pkg::N; i++) begin
                for (int c = 0; c < spmm_dim_pkg::N; c++) begin
                    prod[i][c] <= lhs_data[i] * rhs_mat[lhs_col[i]][c];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/segment_reduce.sv ====
`timescale 1ns/1ps
`default_nettype none

module segment_reduce (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        prod_valid,
    input  wire spmm_dim_pkg::data_t   prod [spmm_dim_pkg::N][spmm_dim_pkg::N],
    input  wire [spmm_dim_pkg::N-1:0]  lane_end,
    input  wire spmm_dim_pkg::idx_t    lane_row [spmm_dim_pkg::N],
    output logic [spmm_dim_pkg::N-1:0] row_valid,
    output spmm_dim_pkg::idx_t         row_id [spmm_dim_pkg::N],
    output spmm_dim_pkg::data_t        row_sum [spmm_dim_pkg::N][spmm_dim_pkg::N]
);

    // lanes by columns
    typedef spmm_dim_pkg::data_t mat_t [spmm_dim_pkg::N][spmm_dim_pkg::N];

    mat_t                              pfx [spmm_dim_pkg::LG_N];
    logic [spmm_dim_pkg::LG_N-1:0]     vld_d;
    logic [spmm_dim_pkg::N-1:0]        end_d [spmm_dim_pkg::LG_N];
    spmm_dim_pkg::idx_t                row_d [spmm_dim_pkg::LG_N][spmm_dim_pkg::N];
    spmm_dim_pkg::data_t               carry [spmm_dim_pkg::N];
    spmm_dim_pkg::data_t               carry_c [spmm_dim_pkg::N];
    spmm_dim_pkg::data_t               base [spmm_dim_pkg::N];
    mat_t                              sum_c;

    // one scan step, each lane adds the lane step positions below it
    function automatic mat_t add_shifted(input mat_t src, input int step);
        mat_t res;
        res = src;
        for (int i = step; i < spmm_dim_pkg::N; i++) begin
            for (int c = 0; c < spmm_dim_pkg::N; c++) begin
                res[i][c] = src[i][c] + src[i - step][c];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clock) begin
        pfx[0]   <= add_shifted(prod, 1);
        row_d[0] <= lane_row;
        for (int k = 1; k < spmm_dim_pkg::LG_N; k++) begin
            pfx[k]   <= add_shifted(pfx[k - 1], 1 << k);
            row_d[k] <= row_d[k - 1];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            vld_d <= '0;
            for (int k = 0; k < spmm_dim_pkg::LG_N; k++) begin
                end_d[k] <= '0;
            end
        end else begin
            vld_d[0] <= prod_valid;
            end_d[0] <= lane_end;
            for (int k = 1; k < spmm_dim_pkg::LG_N; k++) begin
                vld_d[k] <= vld_d[k - 1];
                end_d[k] <= end_d[k - 1];
            end
        end
    end

    // base starts as -carry, so the first end in a beat picks up the carry
    // and later ends subtract the prefix at the previous end
    always_comb begin
        for (int c = 0; c < spmm_dim_pkg::N; c++) begin
            base[c] = '0 - carry[c];
            for (int i = 0; i < spmm_dim_pkg::N; i++) begin
                sum_c[i][c] = pfx[spmm_dim_pkg::LG_N - 1][i][c] - base[c];
                if (end_d[spmm_dim_pkg::LG_N - 1][i]) begin
                    base[c] = pfx[spmm_dim_pkg::LG_N - 1][i][c];
                end
            end
            // remainder after the last end, or carry plus beat total if none
            carry_c[c] = pfx[spmm_dim_pkg::LG_N - 1][spmm_dim_pkg::N - 1][c] - base[c];
        end
    end

    // a job's last lane always closes row N-1, which leaves the carry at zero
    // for the first beat of the next job
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            row_valid <= '0;
            for (int c = 0; c < spmm_dim_pkg::N; c++) begin
                carry[c] <= '0;
            end
        end else begin
            row_valid <= vld_d[spmm_dim_pkg::LG_N - 1] ? end_d[spmm_dim_pkg::LG_N - 1] : '0;
            if (vld_d[spmm_dim_pkg::LG_N - 1]) begin
                carry <= carry_c;
            end
        end
    end

    always_ff @(posedge clock) begin
        row_id  <= row_d[spmm_dim_pkg::LG_N - 1];
        row_sum <= sum_c;
    end

endmodule

`default_nettype wire

// ==== hw/result_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_buffer (
    input  wire                       clock,
    input  wire [spmm_dim_pkg::N-1:0] row_valid,
    input  wire spmm_dim_pkg::idx_t   row_id [spmm_dim_pkg::N],
    input  wire spmm_dim_pkg::data_t  row_sum [spmm_dim_pkg::N][spmm_dim_pkg::N],
    input  wire                       out_rd,
    input  wire spmm_dim_pkg::idx_t   out_idx,
    output spmm_dim_pkg::data_t       out_row [spmm_dim_pkg::N]
);

    spmm_dim_pkg::data_t mem [spmm_dim_pkg::N][spmm_dim_pkg::N];

    // every row ends once per job, so ending lanes never share a row id
    always_ff @(posedge clock) begin
        for (int i = 0; i < spmm_dim_pkg::N; i++) begin
            if (row_valid[i]) begin
                mem[row_id[i]] <= row_sum[i];
            end
        end
    end

    // rows stay in place until the output burst reads them
    always_ff @(posedge clock) begin
        if (out_rd) begin
            out_row <= mem[out_idx];
        end
    end

endmodule

`default_nettype wire

// ==== hw/spmm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_top (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      rhs_start,
    input  wire spmm_dim_pkg::data_t rhs_row [spmm_dim_pkg::N],
    output logic                     rhs_ready,
    input  wire                      lhs_start,
    input  wire spmm_dim_pkg::ptr_t  lhs_ptr [spmm_dim_pkg::N],
    input  wire spmm_dim_pkg::data_t lhs_data [spmm_dim_pkg::N],
    input  wire spmm_dim_pkg::idx_t  lhs_col [spmm_dim_pkg::N],
    output logic                     lhs_ready,
    input  wire                      out_start,
    output logic                     out_ready,
    output logic                     out_valid,
    output spmm_dim_pkg::data_t      out_row [spmm_dim_pkg::N]
);

    logic                       rhs_we;
    logic                       lhs_accept;
    logic                       lhs_first;
    logic                       out_rd;
    spmm_dim_pkg::idx_t         rhs_idx;
    spmm_dim_pkg::idx_t         lhs_beat;
    spmm_dim_pkg::idx_t         out_idx;
    spmm_dim_pkg::data_t        rhs_mat [spmm_dim_pkg::N][spmm_dim_pkg::N];
    spmm_dim_pkg::data_t        prod [spmm_dim_pkg::N][spmm_dim_pkg::N];
    logic                       prod_valid;
    logic [spmm_dim_pkg::N-1:0] lane_end;
    spmm_dim_pkg::idx_t         lane_row [spmm_dim_pkg::N];
    logic [spmm_dim_pkg::N-1:0] row_valid;
    spmm_dim_pkg::idx_t         row_id [spmm_dim_pkg::N];
    spmm_dim_pkg::data_t        row_sum [spmm_dim_pkg::N][spmm_dim_pkg::N];

    spmm_ctrl ctrl_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .rhs_start  (rhs_start),
        .lhs_start  (lhs_start),
        .out_start  (out_start),
        .rhs_ready  (rhs_ready),
        .lhs_ready  (lhs_ready),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .rhs_we     (rhs_we),
        .lhs_accept (lhs_accept),
        .lhs_first  (lhs_first),
        .out_rd     (out_rd),
        .rhs_idx    (rhs_idx),
        .lhs_beat   (lhs_beat),
        .out_idx    (out_idx)
    );

    rhs_buffer rhs_buffer_i (
        .clock   (clock),
        .rhs_we  (rhs_we),
        .rhs_idx (rhs_idx),
        .rhs_row (rhs_row),
        .rhs_mat (rhs_mat)
    );

    csr_decode csr_decode_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .lhs_accept (lhs_accept),
        .lhs_first  (lhs_first),
        .lhs_beat   (lhs_beat),
        .lhs_ptr    (lhs_ptr),
        .lane_end   (lane_end),
        .lane_row   (lane_row)
    );

    product_stage product_stage_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .lhs_accept (lhs_accept),
        .lhs_data   (lhs_data),
        .lhs_col    (lhs_col),
        .rhs_mat    (rhs_mat),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    segment_reduce segment_reduce_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .prod_valid (prod_valid),
        .prod       (prod),
        .lane_end   (lane_end),
        .lane_row   (lane_row),
        .row_valid  (row_valid),
        .row_id     (row_id),
        .row_sum    (row_sum)
    );

    result_buffer result_buffer_i (
        .clock     (clock),
        .row_valid (row_valid),
        .row_id    (row_id),
        .row_sum   (row_sum),
        .out_rd    (out_rd),
        .out_idx   (out_idx),
        .out_row   (out_row)
    );

endmodule

`default_nettype wire

// ==== sim/spmm_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_assert (
    input wire clock,
    input wire reset_n,
    input wire rhs_ready,
    input wire lhs_ready,
    input wire out_ready,
    input wire out_valid
);

    // length of the current out_valid run
    int valid_run;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_run <= 0;
        end else if (out_valid) begin
            valid_run <= valid_run + 1;
        end else begin
            valid_run <= 0;
        end
    end

    ready_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0({rhs_ready, lhs_ready, out_ready}))
        else $error("more than one ready is high");

    valid_no_ready: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid |-> !(rhs_ready || lhs_ready || out_ready))
        else $error("out_valid is high together with a ready");

    valid_not_long: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid |-> (valid_run < spmm_dim_pkg::N))
        else $error("out_valid stays high too long");

    valid_not_short: assert property (@(posedge clock) disable iff (!reset_n)
        $fell(out_valid) |-> (valid_run == spmm_dim_pkg::N))
        else $error("out_valid falls too early");

    reset_quiet: assert property (@(posedge clock)
        !reset_n |-> !(rhs_ready || lhs_ready || out_ready || out_valid))
        else $error("ready or out_valid high in reset");

endmodule

bind spmm_top spmm_assert spmm_assert_i (
    .clock     (clock),
    .reset_n   (reset_n),
    .rhs_ready (rhs_ready),
    .lhs_ready (lhs_ready),
    .out_ready (out_ready),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== sim/spmm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spmm_tb;

    localparam int N = spmm_dim_pkg::N;
    localparam int NUM_CASES = 6;
    localparam int TIMEOUT_CYCLES =
        NUM_CASES * (3 * N + spmm_ctrl_pkg::PIPE_LATENCY + 10) + 50;

    // row-end pointers packed as {p3, p2, p1, p0}
    localparam logic [15:0] CASE_PTR [NUM_CASES] = '{
        16'hFB73, 16'hFD65, 16'hF210, 16'hFA92, 16'hF841, 16'hF876
    };
    // column of position p in bits [2p+1:2p], beat 0 in the low byte
    localparam logic [31:0] CASE_COL [NUM_CASES] = '{
        32'h4E_B1_1B_E4, 32'hD8_72_9C_36, 32'h1B_00_55_A5,
        32'hE4_FF_27_8D, 32'h39_C6_AA_0F, 32'h5A_E1_3C_96
    };
    // random nonzeros, early out_start pulse, idle cycles before out_start
    localparam bit CASE_RND [NUM_CASES] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
    localparam bit CASE_EARLY [NUM_CASES] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    localparam int CASE_WAIT [NUM_CASES] = '{0, 2, 1, 0, 0, 3};

    logic                clock;
    logic                reset_n;
    logic                rhs_start;
    logic                lhs_start;
    logic                out_start;
    spmm_dim_pkg::data_t rhs_row [N];
    spmm_dim_pkg::ptr_t  lhs_ptr [N];
    spmm_dim_pkg::data_t lhs_data [N];
    spmm_dim_pkg::idx_t  lhs_col [N];
    logic                rhs_ready;
    logic                lhs_ready;
    logic                out_ready;
    logic                out_valid;
    spmm_dim_pkg::data_t out_row [N];

    // current job as the testbench sees it
    spmm_dim_pkg::data_t rhs_mat [N][N];
    spmm_dim_pkg::ptr_t  job_ptr [N];
    spmm_dim_pkg::idx_t  job_col [N * N];
    spmm_dim_pkg::data_t job_data [N * N];
    spmm_dim_pkg::data_t exp_row [N][N];

    int errors;
    int checks;
    int cycle_count;

    spmm_top spmm_top_i (
        .clock     (clock),
        .reset_n   (reset_n),
        .rhs_start (rhs_start),
        .rhs_row   (rhs_row),
        .rhs_ready (rhs_ready),
        .lhs_start (lhs_start),
        .lhs_ptr   (lhs_ptr),
        .lhs_data  (lhs_data),
        .lhs_col   (lhs_col),
        .lhs_ready (lhs_ready),
        .out_start (out_start),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_row   (out_row)
    );

    initial begin
        clock = 1'b0;
    end

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // modulo 2^8 row sums over each row's span of flattened positions
    task automatic build_expected();
        int first;
        spmm_dim_pkg::data_t acc;
        first = 0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                acc = '0;
                for (int p = first; p <= int'(job_ptr[r]); p++) begin
                    acc = acc + job_data[p] * rhs_mat[job_col[p]][c];
                end
                exp_row[r][c] = acc;
            end
            first = int'(job_ptr[r]) + 1;
        end
    endtask

    task automatic prepare_job(input int k);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                rhs_mat[r][c] = spmm_dim_pkg::data_t'($urandom());
            end
            job_ptr[r] = CASE_PTR[k][4 * r +: 4];
        end
        for (int p = 0; p < N * N; p++) begin
            job_col[p] = CASE_COL[k][2 * p +: 2];
            if (CASE_RND[k]) begin
                job_data[p] = spmm_dim_pkg::data_t'($urandom());
            end else if (p % 5 == 4) begin
                // padding nonzero
                job_data[p] = '0;
            end else begin
                job_data[p] = spmm_dim_pkg::data_t'(p * 29 + 3);
            end
        end
        build_expected();
    endtask

    task automatic load_rhs();
        while (!rhs_ready) begin
            compare_value("lhs_ready", 32'(lhs_ready), 32'd0);
            compare_value("out_ready", 32'(out_ready), 32'd0);
            compare_value("out_valid", 32'(out_valid), 32'd0);
            @(negedge clock);
        end
        for (int b = 0; b < N; b++) begin
            // rhs_ready drops once the burst is accepted, the others stay low
            compare_value("rhs_ready", 32'(rhs_ready), 32'(b == 0));
            compare_value("lhs_ready", 32'(lhs_ready), 32'd0);
            compare_value("out_ready", 32'(out_ready), 32'd0);
            rhs_start = (b == 0);
            rhs_row = rhs_mat[b];
            @(negedge clock);
        end
        rhs_start = 1'b0;
    endtask

    task automatic load_lhs();
        while (!lhs_ready) begin
            compare_value("rhs_ready", 32'(rhs_ready), 32'd0);
            compare_value("out_ready", 32'(out_ready), 32'd0);
            @(negedge clock);
        end
        for (int b = 0; b < N; b++) begin
            compare_value("lhs_ready", 32'(lhs_ready), 32'(b == 0));
            compare_value("rhs_ready", 32'(rhs_ready), 32'd0);
            compare_value("out_ready", 32'(out_ready), 32'd0);
            lhs_start = (b == 0);
            for (int l = 0; l < N; l++) begin
                // pointers only count on the start beat
                lhs_ptr[l] = (b == 0) ? job_ptr[l] : ~job_ptr[l];
                lhs_data[l] = job_data[b * N + l];
                lhs_col[l] = job_col[b * N + l];
            end
            @(negedge clock);
        end
        lhs_start = 1'b0;
    endtask

    task automatic read_out(input int k);
        if (CASE_EARLY[k]) begin
            compare_value("out_ready", 32'(out_ready), 32'd0);
            out_start = 1'b1;
            @(negedge clock);
            out_start = 1'b0;
        end
        while (!out_ready) begin
            compare_value("rhs_ready", 32'(rhs_ready), 32'd0);
            compare_value("lhs_ready", 32'(lhs_ready), 32'd0);
            compare_value("out_valid", 32'(out_valid), 32'd0);
            @(negedge clock);
        end
        // results must hold while out_ready waits
        repeat (CASE_WAIT[k]) begin
            compare_value("out_valid", 32'(out_valid), 32'd0);
            @(negedge clock);
        end
        out_start = 1'b1;
        @(negedge clock);
        out_start = 1'b0;
        for (int r = 0; r < N; r++) begin
            compare_value("out_valid", 32'(out_valid), 32'd1);
            for (int c = 0; c < N; c++) begin
                compare_value($sformatf("out_row[%0d][%0d] job %0d", r, c, k),
                              32'(out_row[c]), 32'(exp_row[r][c]));
            end
            @(negedge clock);
        end
        compare_value("out_valid", 32'(out_valid), 32'd0);
    endtask

    initial begin
        void'($urandom(32'h527));
        errors = 0;
        checks = 0;
        cycle_count = 0;
        reset_n = 1'b0;
        rhs_start = 1'b0;
        lhs_start = 1'b0;
        out_start = 1'b0;
        for (int l = 0; l < N; l++) begin
            rhs_row[l] = '0;
            lhs_ptr[l] = '0;
            lhs_data[l] = '0;
            lhs_col[l] = '0;
        end
        repeat (8) @(negedge clock);
        compare_value("rhs_ready", 32'(rhs_ready), 32'd0);
        compare_value("lhs_ready", 32'(lhs_ready), 32'd0);
        compare_value("out_ready", 32'(out_ready), 32'd0);
        compare_value("out_valid", 32'(out_valid), 32'd0);
        reset_n = 1'b1;
        @(negedge clock);
        compare_value("rhs_ready", 32'(rhs_ready), 32'd1);
        compare_value("lhs_ready", 32'(lhs_ready), 32'd0);
        compare_value("out_ready", 32'(out_ready), 32'd0);
        compare_value("out_valid", 32'(out_valid), 32'd0);

        for (int k = 0; k < NUM_CASES; k++) begin
            prepare_job(k);
            load_rhs();
            load_lhs();
            read_out(k);
        end

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/spmm_dim_pkg.sv
hw/spmm_ctrl_pkg.sv
hw/rhs_buffer.sv
hw/spmm_ctrl.sv
hw/csr_decode.sv
hw/product_stage.sv
hw/segment_reduce.sv
hw/result_buffer.sv
hw/spmm_top.sv
sim/spmm_assert.sv
sim/spmm_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the spmm testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module spmm_tb -f build.f -o spmm_sim

./obj_dir/spmm_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
